//--- hw/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W     = 8;    // data and instruction width
    localparam int REG_CNT    = 4;    // general purpose registers
    localparam int IMEM_DEPTH = 256;  // instruction words

    typedef logic [DATA_W-1:0]             word_t;     // data or instruction word
    typedef logic [$clog2(REG_CNT)-1:0]    reg_idx_t;  // register index
    typedef logic [$clog2(IMEM_DEPTH)-1:0] pc_t;       // instruction address

    // instruction word: opcode 7:4, ra 3:2, rb 1:0
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,   // no operation
        OP_MOV = 4'd1,   // ra = rb
        OP_ADD = 4'd2,   // ra = ra + rb
        OP_SUB = 4'd3,   // ra = ra - rb
        OP_AND = 4'd4,   // ra = ra & rb
        OP_OR  = 4'd5,   // ra = ra | rb
        OP_NOT = 4'd6,   // ra = ~rb
        OP_INC = 4'd7,   // ra = ra + 1
        OP_DEC = 4'd8,   // ra = ra - 1
        OP_IN  = 4'd9,   // ra = in_port
        OP_OUT = 4'd10,  // out_port = rb
        OP_JZ  = 4'd11,  // pc = rb if z
        OP_JN  = 4'd12,  // pc = rb if n
        OP_JC  = 4'd13,  // pc = rb if c
        OP_JMP = 4'd14,  // pc = rb
        OP_HLT = 4'd15   // stop
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_INC, ALU_DEC
    } alu_op_e;

    // condition code layout, v in bit 3
    typedef struct packed {
        logic v;  // signed overflow
        logic c;  // carry out, borrow on sub/dec
        logic n;  // msb of result
        logic z;  // result is zero
    } flags_t;

endpackage

//--- hw/pipe_if.sv
`timescale 1ns/1ps

// decode to execute pipeline register contents
interface id_ex_if;
    logic               valid;      // low means bubble
    cpu_pkg::alu_op_e   alu_op;
    logic               reg_write;  // write rd at wb
    cpu_pkg::reg_idx_t  rd;
    logic               out_write;  // OUT instruction
    logic               in_sel;     // result from in_port
    cpu_pkg::opcode_e   br_type;    // branch opcode, OP_NOP when none
    logic               halt;       // HLT instruction
    cpu_pkg::reg_idx_t  ra;         // source indices for forwarding
    cpu_pkg::reg_idx_t  rb;
    cpu_pkg::word_t     ra_val;     // operand values read in decode
    cpu_pkg::word_t     rb_val;

    modport dec (output valid, alu_op, reg_write, rd, out_write, in_sel, br_type, halt,
                        ra, rb, ra_val, rb_val);
    modport exe (input  valid, alu_op, reg_write, rd, out_write, in_sel, br_type, halt,
                        ra, rb, ra_val, rb_val);
endinterface

// execute to writeback register, fans out to rf, bypass and forward
interface wb_if;
    logic               reg_write;  // one cycle strobe
    cpu_pkg::reg_idx_t  rd;
    cpu_pkg::word_t     result;
    logic               out_write;  // one cycle strobe to out_port

    modport src (output reg_write, rd, result, out_write);
    modport dst (input  reg_write, rd, result);  // register file side
    modport fwd (input  reg_write, rd, result);  // ex operand forward
endinterface

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,          // ra operand
    input  cpu_pkg::word_t   b,          // rb operand
    input  cpu_pkg::alu_op_e op,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flags_t  flags,      // all four, always computed
    output cpu_pkg::flags_t  flag_mask   // which flags this op updates
);

    logic [cpu_pkg::DATA_W:0] sum;       // extra bit is carry/borrow
    cpu_pkg::word_t           y;         // second adder input
    logic                     sub_op;

    // inc/dec reuse the adder with a constant one
    assign sub_op = (op == cpu_pkg::ALU_SUB) || (op == cpu_pkg::ALU_DEC);
    assign y      = (op == cpu_pkg::ALU_INC || op == cpu_pkg::ALU_DEC) ?
                    cpu_pkg::word_t'(1) : b;
    assign sum    = sub_op ? {1'b0, a} - {1'b0, y} : {1'b0, a} + {1'b0, y};

    always_comb begin
        result    = b;   // pass
        flag_mask = '0;  // pass touches no flags
        case (op)
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB, cpu_pkg::ALU_INC, cpu_pkg::ALU_DEC: begin
                result    = sum[cpu_pkg::DATA_W-1:0];
                flag_mask = '1;
            end
            cpu_pkg::ALU_AND: begin
                result      = a & b;
                flag_mask.z = 1'b1;
                flag_mask.n = 1'b1;
            end
            cpu_pkg::ALU_OR: begin
                result      = a | b;
                flag_mask.z = 1'b1;
                flag_mask.n = 1'b1;
            end
            cpu_pkg::ALU_NOT: begin
                result      = ~b;
                flag_mask.z = 1'b1;
                flag_mask.n = 1'b1;
            end
            default: ;
        endcase
    end

    assign flags.z = (result == '0);
    assign flags.n = result[cpu_pkg::DATA_W-1];
    assign flags.c = sum[cpu_pkg::DATA_W];  // borrow when subtracting
    // overflow: sign of result differs from sign expected by the operands
    assign flags.v = (sub_op ? (a[cpu_pkg::DATA_W-1] != y[cpu_pkg::DATA_W-1])
                             : (a[cpu_pkg::DATA_W-1] == y[cpu_pkg::DATA_W-1]))
                     && (sum[cpu_pkg::DATA_W-1] != a[cpu_pkg::DATA_W-1]);

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            run,            // level, freezes fetch when low
    input  logic            prog_we,        // program load strobe
    input  cpu_pkg::pc_t    prog_addr,
    input  cpu_pkg::word_t  prog_data,
    input  logic            branch_taken,   // from ex, redirect and flush
    input  cpu_pkg::pc_t    branch_target,
    input  logic            halted,
    output cpu_pkg::word_t  instr,          // if/id instruction
    output logic            instr_valid     // if/id valid
);

    cpu_pkg::word_t imem [cpu_pkg::IMEM_DEPTH];  // program store

    cpu_pkg::pc_t   pc;
    cpu_pkg::word_t fetch_word;
    logic           fetch_en;

    // advance only when running and nothing redirects
    assign fetch_en   = run && !halted && !branch_taken;
    assign fetch_word = imem[pc];  // async read

    // load port, works with run high or low
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;  // target fetched next cycle
        end else if (fetch_en) begin
            pc <= pc + 1'b1;
        end
    end

    // valid bit of if/id
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= fetch_en;  // branch or halt gives a bubble
        end
    end

    // payload, meaningless while valid is low
    always_ff @(posedge clk) begin
        instr <= fetch_word;
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic            clk,
    input  logic            arst_n,
    input  cpu_pkg::word_t  instr,         // if/id word
    input  logic            instr_valid,
    input  logic            branch_taken,  // flush the slot in decode
    input  logic            halted,
    id_ex_if.dec            id_ex,
    wb_if.dst               wb
);

    cpu_pkg::word_t     regs [cpu_pkg::REG_CNT];  // register file

    cpu_pkg::opcode_e   opcode;
    cpu_pkg::reg_idx_t  ra_idx;
    cpu_pkg::reg_idx_t  rb_idx;
    cpu_pkg::word_t     ra_val;
    cpu_pkg::word_t     rb_val;

    cpu_pkg::alu_op_e   alu_op;
    logic               reg_write;
    logic               out_write;
    logic               in_sel;
    cpu_pkg::opcode_e   br_type;
    logic               halt;
    logic               issue;

    assign opcode = cpu_pkg::opcode_e'(instr[7:4]);
    assign ra_idx = instr[3:2];
    assign rb_idx = instr[1:0];

    // read with bypass of the write landing this cycle
    assign ra_val = (wb.reg_write && wb.rd == ra_idx) ? wb.result : regs[ra_idx];
    assign rb_val = (wb.reg_write && wb.rd == rb_idx) ? wb.result : regs[rb_idx];

    assign issue = instr_valid && !branch_taken && !halted;  // else bubble

    // control decode
    always_comb begin
        alu_op    = cpu_pkg::ALU_PASS;  // pass forwards rb
        reg_write = 1'b0;
        out_write = 1'b0;
        in_sel    = 1'b0;
        br_type   = cpu_pkg::OP_NOP;
        halt      = 1'b0;
        case (opcode)
            cpu_pkg::OP_MOV: reg_write = 1'b1;
            cpu_pkg::OP_ADD: begin
                alu_op    = cpu_pkg::ALU_ADD;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_SUB: begin
                alu_op    = cpu_pkg::ALU_SUB;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_AND: begin
                alu_op    = cpu_pkg::ALU_AND;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_OR: begin
                alu_op    = cpu_pkg::ALU_OR;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_NOT: begin
                alu_op    = cpu_pkg::ALU_NOT;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_INC: begin
                alu_op    = cpu_pkg::ALU_INC;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_DEC: begin
                alu_op    = cpu_pkg::ALU_DEC;
                reg_write = 1'b1;
            end
            cpu_pkg::OP_IN: begin
                in_sel    = 1'b1;  // result taken from in_port in ex
                reg_write = 1'b1;
            end
            cpu_pkg::OP_OUT: out_write = 1'b1;  // rb passes through alu
            cpu_pkg::OP_JZ, cpu_pkg::OP_JN, cpu_pkg::OP_JC, cpu_pkg::OP_JMP: begin
                br_type = opcode;  // resolved against ccr in ex
            end
            cpu_pkg::OP_HLT: halt = 1'b1;
            default: ;  // nop
        endcase
    end

    // register file, written from wb
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < cpu_pkg::REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // id/ex control half
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex.valid     <= 1'b0;
            id_ex.reg_write <= 1'b0;
            id_ex.out_write <= 1'b0;
            id_ex.br_type   <= cpu_pkg::OP_NOP;
            id_ex.halt      <= 1'b0;
        end else begin
            id_ex.valid     <= issue;
            id_ex.reg_write <= reg_write;
            id_ex.out_write <= out_write;
            id_ex.br_type   <= br_type;
            id_ex.halt      <= halt;
        end
    end

    // id/ex payload half
    always_ff @(posedge clk) begin
        id_ex.alu_op <= alu_op;
        id_ex.in_sel <= in_sel;
        id_ex.rd     <= ra_idx;  // destination is always ra
        id_ex.ra     <= ra_idx;
        id_ex.rb     <= rb_idx;
        id_ex.ra_val <= ra_val;
        id_ex.rb_val <= rb_val;
    end

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            arst_n,
    input  cpu_pkg::word_t  in_port,        // sampled by IN in ex
    id_ex_if.exe            id_ex,
    wb_if.src               wb_out,         // ex/wb register
    wb_if.fwd               wb_fwd,         // same register read back
    output logic            branch_taken,
    output cpu_pkg::pc_t    branch_target,
    output logic            halted          // sticky after HLT
);

    cpu_pkg::word_t  op_a;
    cpu_pkg::word_t  op_b;
    cpu_pkg::word_t  alu_result;
    cpu_pkg::flags_t alu_flags;
    cpu_pkg::flags_t alu_mask;
    cpu_pkg::flags_t ccr;        // condition code register
    logic            ex_valid;
    logic            br_cond;

    // once halted, anything still in flight behind HLT is dropped
    assign ex_valid = id_ex.valid && !halted;

    // wb to ex forward
    assign op_a = (wb_fwd.reg_write && wb_fwd.rd == id_ex.ra) ? wb_fwd.result : id_ex.ra_val;
    assign op_b = (wb_fwd.reg_write && wb_fwd.rd == id_ex.rb) ? wb_fwd.result : id_ex.rb_val;

    alu u_alu (
        .a         (op_a),
        .b         (op_b),
        .op        (id_ex.alu_op),
        .result    (alu_result),
        .flags     (alu_flags),
        .flag_mask (alu_mask)
    );

    // branches look at the flags of the previous instruction
    always_comb begin
        case (id_ex.br_type)
            cpu_pkg::OP_JZ:  br_cond = ccr.z;
            cpu_pkg::OP_JN:  br_cond = ccr.n;
            cpu_pkg::OP_JC:  br_cond = ccr.c;
            cpu_pkg::OP_JMP: br_cond = 1'b1;
            default:         br_cond = 1'b0;
        endcase
    end

    assign branch_taken  = ex_valid && br_cond;
    assign branch_target = op_b;  // register indirect

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ccr              <= '0;
            halted           <= 1'b0;
            wb_out.reg_write <= 1'b0;
            wb_out.out_write <= 1'b0;
        end else begin
            if (ex_valid) begin
                ccr <= cpu_pkg::flags_t'((ccr & ~alu_mask) | (alu_flags & alu_mask));
            end
            halted           <= halted || (ex_valid && id_ex.halt);
            wb_out.reg_write <= ex_valid && id_ex.reg_write;
            wb_out.out_write <= ex_valid && id_ex.out_write;
        end
    end

    // wb payload
    always_ff @(posedge clk) begin
        wb_out.rd     <= id_ex.rd;
        wb_out.result <= id_ex.in_sel ? in_port : alu_result;
    end

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            run,        // fetch enable level
    input  logic            prog_we,    // program load
    input  cpu_pkg::pc_t    prog_addr,
    input  cpu_pkg::word_t  prog_data,
    input  cpu_pkg::word_t  in_port,
    output cpu_pkg::word_t  out_port,   // zero unless out_valid
    output logic            out_valid,  // one pulse per OUT
    output logic            halted
);

    cpu_pkg::word_t instr;
    logic           instr_valid;
    logic           branch_taken;
    cpu_pkg::pc_t   branch_target;

    id_ex_if id_ex ();
    wb_if    wb ();

    fetch_stage u_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .run           (run),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halted        (halted),
        .instr         (instr),
        .instr_valid   (instr_valid)
    );

    decode_stage u_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .branch_taken (branch_taken),
        .halted       (halted),
        .id_ex        (id_ex),
        .wb           (wb)
    );

    execute_stage u_execute (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_port       (in_port),
        .id_ex         (id_ex),
        .wb_out        (wb),
        .wb_fwd        (wb),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halted        (halted)
    );

    // output port straight off the wb strobe
    assign out_valid = wb.out_write;
    assign out_port  = wb.out_write ? wb.result : '0;

endmodule

//--- test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    localparam int    CLK_PERIOD      = 20;
    localparam int    RESET_CYCLES    = 3;
    localparam int    CYCLES_PER_WORD = 40;   // watchdog budget per program word
    localparam int    WATCHDOG_MARGIN = 100;
    localparam int    DRAIN_CYCLES    = 8;    // quiet time after halted
    localparam int    GOLDEN_DEPTH    = 256;
    localparam string GOLDEN_FILE     = "test/cpu_golden.txt";

    logic           clk;
    logic           arst_n;
    logic           run;
    logic           prog_we;
    cpu_pkg::pc_t   prog_addr;
    cpu_pkg::word_t prog_data;
    cpu_pkg::word_t in_port;
    cpu_pkg::word_t out_port;
    logic           out_valid;
    logic           halted;

    cpu_pkg::word_t golden [GOLDEN_DEPTH];  // flat image of the golden file
    int             prog_len;
    int             exp_count;
    int             exp_base;                // index of first expected out_port
    int             out_count;
    int             idle_cycles;

    cpu_top uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .in_port   (in_port),
        .out_port  (out_port),
        .out_valid (out_valid),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic read_golden();
        for (int i = 0; i < GOLDEN_DEPTH; i++) begin
            golden[i] = '0;
        end
        $readmemh(GOLDEN_FILE, golden);
        if (golden[0] == '0) begin
            $display("golden file %s is missing or holds no program", GOLDEN_FILE);
            $display("TEST FAIL");
            $fatal(1, "no stimulus");
        end
        prog_len  = int'(golden[0]);
        exp_count = int'(golden[prog_len + 2]);  // follows length, words and in_port
        exp_base  = prog_len + 3;
    endtask

    // program port writes one word per clock
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= cpu_pkg::pc_t'(i);
            prog_data <= golden[1 + i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // port monitor sampling mid cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (!run) begin
                check_value("out_valid", out_valid, 32'd0);  // quiet before run
                check_value("halted", halted, 32'd0);
            end
            if (!out_valid) begin
                check_value("out_port", out_port, 32'd0);
            end
            if (halted) begin
                check_value("out_valid", out_valid, 32'd0);  // nothing after HLT
            end
            if (out_valid) begin
                if (out_count >= exp_count) begin
                    check_value("out_count", out_count + 1, exp_count);  // extra pulse
                end else begin
                    check_value("out_port", out_port, golden[exp_base + out_count]);
                end
                out_count = out_count + 1;
            end
        end
    end

    initial begin
        wait (prog_len != 0);
        repeat (prog_len * CYCLES_PER_WORD + WATCHDOG_MARGIN) @(posedge clk);
        $display("timeout: halted never rose within %0d cycles",
                 prog_len * CYCLES_PER_WORD + WATCHDOG_MARGIN);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        arst_n    = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        in_port   = '0;
        out_count = 0;
        idle_cycles = int'($urandom(32'h63c66d6e) % 8);  // seeded draw of 0 to 7 idle cycles
        read_golden();

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n  <= 1'b1;
        in_port <= golden[prog_len + 1];
        load_program();  // run still low
        repeat (idle_cycles) @(posedge clk);
        run <= 1'b1;

        while (!halted) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        @(posedge clk);
        check_value("out_count", out_count, exp_count);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- sources.f
hw/cpu_pkg.sv
hw/pipe_if.sv
hw/alu.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/cpu_top.sv
test/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the cpu testbench with verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module cpu_tb -Mdir obj_dir -o Vcpu_tb \
    -f sources.f

result=$(./obj_dir/Vcpu_tb 2>&1 || true)
echo "$result"

if echo "$result" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- test/cpu_golden.txt
// cpu program image and expected port traffic, hex, one field after another:
// program length, program words, in_port value, out_valid pulse count, out_port values
3c
// program words from address 0 upward
90 a0 14 68 26 a1 74 38
54 a2 42 88 a1 a0 a2 7c
7c 7c 7c 7c 18 2b 35 b2
a0 a0 c2 a0 d2 a3 2b 2b
84 d2 a1 a1 b2 a1 2b 2b
60 c2 a0 a0 a0 a0 a0 2b
2b e2 a1 a1 a1 a1 a1 a1
a2 f0 a1 a1
// in_port value
35
// out_valid pulse count
0b
// out_port values in order
35 ff 95 35 15 94 15 05
ff ea 38
